//--- packet_switch.f
common/switch_pkg.sv
hdl/ingress_framer.sv
voq_buffer/voq_fifo.sv
voq_buffer/voq_buffer.sv
hdl/egress_scheduler.sv
hdl/packet_switch.sv
sim/tb_switch_checks.sv
sim/tb_packet_switch.sv

//--- sim/tb_packet_switch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_packet_switch;

    import switch_pkg::*;

    localparam int pkts_per_src   = 12;
    localparam int num_tests      = 4;
    localparam int total_pkts     = pkts_per_src * port_count * num_tests;
    localparam int timeout_cycles = total_pkts * max_pkt_words * port_count * 4 + 200;

    logic                              clk;
    logic                              rst_n;
    logic [port_count-1:0]             wr_sop;
    logic [port_count-1:0]             wr_eop;
    logic [port_count-1:0]             wr_vld;
    logic [port_count-1:0][data_w-1:0] wr_data;
    logic [port_count-1:0]             ready;
    logic [port_count-1:0]             fault_mark;
    logic                              rand_ready;
    logic                              full_check;
    logic [7:0]                        seq [port_count];
    int                                seed;
    int                                word_errors;
    int                                prop_errors;

    wire [port_count-1:0]              rd_sop;
    wire [port_count-1:0]              rd_eop;
    wire [port_count-1:0]              rd_vld;
    wire [port_count-1:0][data_w-1:0]  rd_data;
    wire [port_count-1:0]              error;
    wire                               full;
    wire                               alm_full;

    packet_switch packet_switch_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_sop   (wr_sop),
        .wr_eop   (wr_eop),
        .wr_vld   (wr_vld),
        .wr_data  (wr_data),
        .rd_sop   (rd_sop),
        .rd_eop   (rd_eop),
        .rd_vld   (rd_vld),
        .rd_data  (rd_data),
        .error    (error),
        .full     (full),
        .alm_full (alm_full),
        .ready    (ready)
    );

    tb_switch_checks checks_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_vld      (rd_vld),
        .rd_sop      (rd_sop),
        .rd_eop      (rd_eop),
        .rd_data     (rd_data),
        .ready       (ready),
        .error       (error),
        .fault_mark  (fault_mark),
        .full        (full),
        .alm_full    (alm_full),
        .full_check  (full_check),
        .word_errors (word_errors),
        .prop_errors (prop_errors)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        #1;
        ready = rand_ready ? port_count'($random(seed)) : '1;
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    // kind 0 good, 1 lone word, 2 repeated sop, 3 nine words
    task automatic send_packet(input int src, input int dst, input int kind, input int max_len);
        int                len;
        logic [data_w-1:0] w;
        case (kind)
            1:       len = 1;
            2:       len = 3;
            3:       len = max_pkt_words + 1;
            default: len = 1 + (($random(seed) & 32'h7fff_ffff) % max_len);
        endcase
        while (alm_full) begin
            @(posedge clk);
            #1;
        end
        for (int k = 0; k < len; k++) begin
            w = (k == 0) ? {4'h0, seq[src], 2'(src), 2'(dst)} : data_w'($random(seed));
            wr_vld[src]     = 1'b1;
            wr_sop[src]     = (kind != 1 && k == 0) || (kind == 2 && k == 1);
            wr_eop[src]     = (k == len - 1);
            wr_data[src]    = w;
            fault_mark[src] = (kind == 1) || (kind == 2 && k == 1) ||
                              (kind == 3 && k == max_pkt_words);
            if (kind == 0) begin
                checks_i.expect_word(src, dst, {k == len - 1, w});
            end
            @(posedge clk);
            #1;
        end
        wr_vld[src]     = 1'b0;
        wr_sop[src]     = 1'b0;
        wr_eop[src]     = 1'b0;
        fault_mark[src] = 1'b0;
        seq[src]        = seq[src] + 1'b1;
        // Let the last word land before alm_full is looked at again
        repeat (2) begin
            @(posedge clk);
            #1;
        end
    endtask

    // mode 0 random dest, 1 faults mixed in, 2 all inputs to output 0
    task automatic run_test(input int mode, input logic rnd_ready);
        rand_ready = rnd_ready;
        full_check = (mode == 2);
        for (int s = 0; s < port_count; s++) begin
            fork
                automatic int src = s;
                for (int n = 0; n < pkts_per_src; n++) begin
                    send_packet(src, (mode == 2) ? 0 : ($random(seed) & 3),
                                (mode == 1) ? n % 4 : 0,
                                (mode == 2) ? max_pkt_words - 1 : max_pkt_words);
                end
            join_none
        end
        wait fork;
        while (checks_i.pending() != 0) begin
            @(posedge clk);
            #1;
        end
        repeat (4) @(posedge clk);
        #1;
        full_check = 1'b0;
    endtask

    initial begin
        seed       = 97;
        rst_n      = 1'b0;
        wr_sop     = '0;
        wr_eop     = '0;
        wr_vld     = '0;
        wr_data    = '0;
        ready      = '1;
        fault_mark = '0;
        rand_ready = 1'b0;
        full_check = 1'b0;
        for (int s = 0; s < port_count; s++) begin
            seq[s] = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        run_test(0, 1'b0);
        run_test(1, 1'b0);
        run_test(0, 1'b1);
        run_test(2, 1'b1);

        $display("Errors: %0d word checks, %0d protocol checks", word_errors, prop_errors);
        if (word_errors == 0 && prop_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles with packets still undelivered",
                 timeout_cycles);
        $display("Errors: %0d word checks, %0d protocol checks", word_errors, prop_errors);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/tb_switch_checks.sv
`timescale 1ns/1ps
`default_nettype none

module tb_switch_checks (
    input  wire                                                      clk,
    input  wire                                                      rst_n,
    input  wire [switch_pkg::port_count-1:0]                         rd_vld,
    input  wire [switch_pkg::port_count-1:0]                         rd_sop,
    input  wire [switch_pkg::port_count-1:0]                         rd_eop,
    input  wire [switch_pkg::port_count-1:0][switch_pkg::data_w-1:0] rd_data,
    input  wire [switch_pkg::port_count-1:0]                         ready,
    input  wire [switch_pkg::port_count-1:0]                         error,
    input  wire [switch_pkg::port_count-1:0]                         fault_mark,
    input  wire                                                      full,
    input  wire                                                      alm_full,
    input  wire                                                      full_check,
    output int                                                       word_errors,
    output int                                                       prop_errors
);

    import switch_pkg::*;

    // Expected words per [src][dest], in send order
    voq_word_t         exp_q [port_count][port_count][$];
    logic              first_next [port_count][port_count];
    logic              in_pkt [port_count];
    logic [port_w-1:0] cur_src [port_count];

    initial begin
        word_errors = 0;
        prop_errors = 0;
        for (int s = 0; s < port_count; s++) begin
            in_pkt[s]  = 1'b0;
            cur_src[s] = '0;
            for (int d = 0; d < port_count; d++) begin
                first_next[s][d] = 1'b1;
            end
        end
    end

    function automatic void word_fail(input string msg);
        word_errors++;
        $display("Fail %0t: %s", $time, msg);
    endfunction

    function automatic void prop_fail(input string msg);
        prop_errors++;
        $display("Fail %0t: %s", $time, msg);
    endfunction

    function automatic void expect_word(input int src, input int dst, input voq_word_t w);
        exp_q[src][dst].push_back(w);
    endfunction

    function automatic int pending();
        int n;
        n = 0;
        for (int s = 0; s < port_count; s++) begin
            for (int d = 0; d < port_count; d++) begin
                n += exp_q[s][d].size();
            end
        end
        return n;
    endfunction

    //////////////////////////////////////////////////
    // Per-word scoreboard
    //////////////////////////////////////////////////

    function automatic void check_word(input int j);
        voq_word_t exp_w;
        int        src;
        if (rd_sop[j]) begin
            assert (!in_pkt[j]) else word_fail($sformatf("output %0d sop inside a packet", j));
            cur_src[j] = rd_data[j][3:2];
            in_pkt[j]  = 1'b1;
        end
        src = cur_src[j];
        assert (in_pkt[j]) else word_fail($sformatf("output %0d word outside a packet", j));
        assert (exp_q[src][j].size() != 0)
        else word_fail($sformatf("output %0d word %h not expected", j, rd_data[j]));
        if (exp_q[src][j].size() != 0) begin
            exp_w = exp_q[src][j].pop_front();
            assert (rd_data[j] == exp_w.data && rd_eop[j] == exp_w.last &&
                    rd_sop[j] == first_next[src][j])
            else word_fail($sformatf("output %0d got %h sop %b eop %b, expected %h eop %b",
                                     j, rd_data[j], rd_sop[j], rd_eop[j],
                                     exp_w.data, exp_w.last));
            first_next[src][j] = exp_w.last;
        end
        if (rd_eop[j]) begin
            in_pkt[j] = 1'b0;
        end
    endfunction

    // Mid-cycle, when outputs and ready have settled
    always @(negedge clk) begin
        if (rst_n) begin
            for (int j = 0; j < port_count; j++) begin
                if (rd_vld[j] && ready[j]) begin
                    check_word(j);
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Protocol properties
    //////////////////////////////////////////////////

    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |=> (rd_vld == '0 && rd_sop == '0 && rd_eop == '0 && error == '0 &&
                    !full && !alm_full)
    ) else prop_fail("outputs not low after reset");

    a_never_full: assert property (@(posedge clk) disable iff (!rst_n)
        full_check |-> !full
    ) else prop_fail("full rose under contention");

    for (genvar i = 0; i < port_count; i++) begin : g_port
        a_err_after_fault: assert property (@(posedge clk) disable iff (!rst_n)
            fault_mark[i] |=> error[i]
        ) else prop_fail($sformatf("port %0d missed an error pulse", i));

        a_err_only_on_fault: assert property (@(posedge clk) disable iff (!rst_n)
            error[i] |-> $past(fault_mark[i])
        ) else prop_fail($sformatf("port %0d spurious error pulse", i));

        a_hold_stalled: assert property (@(posedge clk) disable iff (!rst_n)
            rd_vld[i] && !ready[i] |=> rd_vld[i] && $stable(rd_data[i]) &&
                                       $stable(rd_sop[i]) && $stable(rd_eop[i])
        ) else prop_fail($sformatf("output %0d changed while stalled", i));
    end

endmodule

`default_nettype wire

//--- hdl/packet_switch.sv
`timescale 1ns/1ps
`default_nettype none

module packet_switch (
    input  wire                                                     clk,
    input  wire                                                     rst_n,
    input  wire [switch_pkg::port_count-1:0]                        wr_sop,
    input  wire [switch_pkg::port_count-1:0]                        wr_eop,
    input  wire [switch_pkg::port_count-1:0]                        wr_vld,
    input  wire [switch_pkg::port_count-1:0][switch_pkg::data_w-1:0] wr_data,
    output wire [switch_pkg::port_count-1:0]                        rd_sop,
    output wire [switch_pkg::port_count-1:0]                        rd_eop,
    output wire [switch_pkg::port_count-1:0]                        rd_vld,
    output wire [switch_pkg::port_count-1:0][switch_pkg::data_w-1:0] rd_data,
    output wire [switch_pkg::port_count-1:0]                        error,
    output wire                                                     full,
    output wire                                                     alm_full,
    input  wire [switch_pkg::port_count-1:0]                        ready
);

    import switch_pkg::*;

    wire in_word_t [port_count-1:0] in_words;
    wire rd_req_t  [port_count-1:0] rd_reqs;
    wire rd_rsp_t  [port_count-1:0] rd_rsps;

    voq_buffer voq_buffer_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_words (in_words),
        .rd_reqs  (rd_reqs),
        .rd_rsps  (rd_rsps),
        .full     (full),
        .alm_full (alm_full)
    );

    for (genvar i = 0; i < port_count; i++) begin : g_port
        ingress_framer ingress_framer_i (
            .clk     (clk),
            .rst_n   (rst_n),
            .wr_sop  (wr_sop[i]),
            .wr_eop  (wr_eop[i]),
            .wr_vld  (wr_vld[i]),
            .wr_data (wr_data[i]),
            .word    (in_words[i]),
            .error   (error[i])
        );

        egress_scheduler egress_scheduler_i (
            .clk     (clk),
            .rst_n   (rst_n),
            .rd_req  (rd_reqs[i]),
            .rd_rsp  (rd_rsps[i]),
            .ready   (ready[i]),
            .rd_vld  (rd_vld[i]),
            .rd_sop  (rd_sop[i]),
            .rd_eop  (rd_eop[i]),
            .rd_data (rd_data[i])
        );
    end

endmodule

`default_nettype wire

//--- hdl/egress_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

module egress_scheduler (
    input  wire                           clk,
    input  wire                           rst_n,
    output switch_pkg::rd_req_t           rd_req,
    input  wire switch_pkg::rd_rsp_t      rd_rsp,
    input  wire                           ready,
    output logic                          rd_vld,
    output logic                          rd_sop,
    output logic                          rd_eop,
    output logic [switch_pkg::data_w-1:0] rd_data
);

    import switch_pkg::*;

    sched_state_t      state;
    logic [port_w-1:0] sel_q;
    logic [port_w-1:0] pick;
    logic              pick_vld;
    logic              first_q;
    logic              load;

    //////////////////////////////////////////////////
    // Round robin, starting one past the last grant
    //////////////////////////////////////////////////

    always_comb begin
        pick     = sel_q;
        pick_vld = 1'b0;
        for (int k = 1; k <= port_count; k++) begin
            if (!pick_vld && rd_rsp.pkt_avail[port_w'(sel_q + k)]) begin
                pick     = port_w'(sel_q + k);
                pick_vld = 1'b1;
            end
        end
    end

    // Refill when the output stage is empty or moving, but not past eop
    assign load = (state == stream) && (!rd_vld || ready) && !(rd_vld && rd_eop);

    always_comb begin
        rd_req.en  = load;
        rd_req.sel = sel_q;
    end

    //////////////////////////////////////////////////
    // FSM and output stage
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= arbitrate;
            sel_q   <= port_w'(port_count - 1);
            first_q <= 1'b0;
            rd_vld  <= 1'b0;
            rd_sop  <= 1'b0;
            rd_eop  <= 1'b0;
        end else begin
            case (state)
                arbitrate: begin
                    if (pick_vld) begin
                        state   <= stream;
                        sel_q   <= pick;
                        first_q <= 1'b1;
                    end
                end
                default: begin
                    if (rd_vld && ready && rd_eop) begin
                        state <= arbitrate;
                    end
                end
            endcase

            if (load) begin
                rd_vld  <= 1'b1;
                rd_sop  <= first_q;
                rd_eop  <= rd_rsp.head.last;
                first_q <= 1'b0;
            end else if (ready) begin
                rd_vld <= 1'b0;
                rd_sop <= 1'b0;
                rd_eop <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            rd_data <= rd_rsp.head.data;
        end
    end

    // A stalled word holds until the consumer takes it
    a_hold_stalled: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_vld && !ready |=> rd_vld && $stable(rd_sop) && $stable(rd_eop) && $stable(rd_data)
    ) else $error("output changed while stalled");

endmodule

`default_nettype wire

//--- voq_buffer/voq_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module voq_buffer (
    input  wire                                                 clk,
    input  wire                                                 rst_n,
    input  wire switch_pkg::in_word_t [switch_pkg::port_count-1:0] in_words,
    input  wire switch_pkg::rd_req_t  [switch_pkg::port_count-1:0] rd_reqs,
    output wire switch_pkg::rd_rsp_t  [switch_pkg::port_count-1:0] rd_rsps,
    output logic                                                full,
    output logic                                                alm_full
);

    import switch_pkg::*;

    // Grids are indexed [dest][src]
    wire voq_word_t          head_grid  [port_count][port_count];
    wire [voq_ptr_w:0]       free_grid  [port_count][port_count];
    wire [port_count-1:0]    avail_grid [port_count];

    //////////////////////////////////////////////////
    // Queue grid
    //////////////////////////////////////////////////

    for (genvar i = 0; i < port_count; i++) begin : g_src
        logic [port_w-1:0] drop_dest;
        wire voq_word_t    wr_word;

        assign wr_word = {in_words[i].last, in_words[i].data};

        // Drops come without a valid word, so keep the packet's dest
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                drop_dest <= '0;
            end else if (in_words[i].valid) begin
                drop_dest <= in_words[i].dest;
            end
        end

        for (genvar j = 0; j < port_count; j++) begin : g_dst
            voq_fifo voq_fifo_i (
                .clk        (clk),
                .rst_n      (rst_n),
                .wr         (in_words[i].valid && in_words[i].dest == port_w'(j)),
                .wr_word    (wr_word),
                .commit     (in_words[i].valid && in_words[i].commit &&
                             in_words[i].dest == port_w'(j)),
                .drop       (in_words[i].drop && drop_dest == port_w'(j)),
                .rd         (rd_reqs[j].en && rd_reqs[j].sel == port_w'(i)),
                .head       (head_grid[j][i]),
                .pkt_avail  (avail_grid[j][i]),
                .free_words (free_grid[j][i])
            );
        end
    end

    //////////////////////////////////////////////////
    // Read side
    //////////////////////////////////////////////////

    for (genvar j = 0; j < port_count; j++) begin : g_out
        assign rd_rsps[j].pkt_avail = avail_grid[j];
        assign rd_rsps[j].head      = head_grid[j][rd_reqs[j].sel];
    end

    // Any queue short of a full packet of room raises alm_full
    always_comb begin
        full     = 1'b0;
        alm_full = 1'b0;
        for (int d = 0; d < port_count; d++) begin
            for (int s = 0; s < port_count; s++) begin
                if (free_grid[d][s] == '0) begin
                    full = 1'b1;
                end
                if (free_grid[d][s] < max_pkt_words) begin
                    alm_full = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- voq_buffer/voq_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module voq_fifo (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              wr,
    input  wire   switch_pkg::voq_word_t     wr_word,
    input  wire                              commit,
    input  wire                              drop,
    input  wire                              rd,
    output switch_pkg::voq_word_t            head,
    output logic                             pkt_avail,
    output logic  [switch_pkg::voq_ptr_w:0]  free_words
);

    import switch_pkg::*;

    voq_word_t          mem [voq_depth];

    // Extra top bit tells full from empty
    logic [voq_ptr_w:0] rd_ptr;
    logic [voq_ptr_w:0] wr_ptr;
    logic [voq_ptr_w:0] cm_ptr;
    logic [voq_ptr_w:0] wr_ptr_nxt;
    logic [voq_ptr_w:0] used;
    logic [voq_ptr_w:0] pkt_cnt;
    logic               pkt_out;

    // Drop falls back to the last committed point
    assign wr_ptr_nxt = drop ? cm_ptr : wr_ptr + (voq_ptr_w+1)'(wr);

    assign used       = wr_ptr - rd_ptr;
    assign free_words = (voq_ptr_w+1)'(voq_depth) - used;
    assign pkt_avail  = (pkt_cnt != '0);
    assign head       = mem[rd_ptr[voq_ptr_w-1:0]];
    assign pkt_out    = rd && head.last;

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_ptr[voq_ptr_w-1:0]] <= wr_word;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr  <= '0;
            wr_ptr  <= '0;
            cm_ptr  <= '0;
            pkt_cnt <= '0;
        end else begin
            wr_ptr <= wr_ptr_nxt;
            if (commit) begin
                cm_ptr <= wr_ptr_nxt;
            end
            if (rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({commit, pkt_out})
                2'b10:   pkt_cnt <= pkt_cnt + 1'b1;
                2'b01:   pkt_cnt <= pkt_cnt - 1'b1;
                default: pkt_cnt <= pkt_cnt;
            endcase
        end
    end

    // Writer must honour alm_full upstream
    a_no_write_full: assert property (
        @(posedge clk) disable iff (!rst_n) wr |-> (free_words != '0)
    ) else $error("write into a full queue");

    // Scheduler only pops from a queue holding a whole packet
    a_no_read_early: assert property (
        @(posedge clk) disable iff (!rst_n) rd |-> pkt_avail
    ) else $error("read with no complete packet");

endmodule

`default_nettype wire

//--- hdl/ingress_framer.sv
`timescale 1ns/1ps
`default_nettype none

module ingress_framer (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           wr_sop,
    input  wire                           wr_eop,
    input  wire                           wr_vld,
    input  wire  [switch_pkg::data_w-1:0] wr_data,
    output switch_pkg::in_word_t          word,
    output logic                          error
);

    import switch_pkg::*;

    framer_state_t                      state;
    logic [$clog2(max_pkt_words+1)-1:0] cnt;
    logic [port_w-1:0]                  dest_q;
    logic                               fault;
    logic                               take;

    // Lone word, repeated sop, or a ninth word
    always_comb begin
        fault = 1'b0;
        if (wr_vld) begin
            case (state)
                idle:    fault = !wr_sop;
                in_pkt:  fault = wr_sop || (cnt == max_pkt_words);
                default: fault = 1'b0;
            endcase
        end
    end

    assign take = wr_vld && !fault && (state != discard);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= idle;
            cnt    <= '0;
            dest_q <= '0;
            word   <= '0;
            error  <= 1'b0;
        end else begin
            error       <= fault;
            word.valid  <= take;
            word.last   <= take && wr_eop;
            word.commit <= take && wr_eop;
            word.drop   <= fault;
            word.data   <= wr_data;
            word.dest   <= (state == idle) ? wr_data[port_w-1:0] : dest_q;

            if (take) begin
                cnt <= (state == idle) ? 1'b1 : cnt + 1'b1;
            end
            if (take && state == idle) begin
                dest_q <= wr_data[port_w-1:0];
            end

            if (fault) begin
                state <= wr_eop ? idle : discard;
            end else if (wr_vld) begin
                case (state)
                    idle:    state <= wr_eop ? idle : in_pkt;
                    in_pkt:  state <= wr_eop ? idle : in_pkt;
                    default: state <= wr_eop ? idle : discard;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- common/switch_pkg.sv
`default_nettype none

package switch_pkg;

    //////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////

    localparam int port_count    = 4;
    localparam int port_w        = 2;
    localparam int data_w        = 16;
    localparam int max_pkt_words = 8;
    localparam int voq_depth     = 16;
    localparam int voq_ptr_w     = 4;

    //////////////////////////////////////////////////
    // Datapath words
    //////////////////////////////////////////////////

    // Framer to buffer, one per input port
    typedef struct packed {
        logic              valid;
        logic [port_w-1:0] dest;
        logic              last;
        logic              commit;
        logic              drop;
        logic [data_w-1:0] data;
    } in_word_t;

    // Queue entry
    typedef struct packed {
        logic              last;
        logic [data_w-1:0] data;
    } voq_word_t;

    typedef struct packed {
        logic              en;
        logic [port_w-1:0] sel;
    } rd_req_t;

    // Combinational on sel
    typedef struct packed {
        logic [port_count-1:0] pkt_avail;
        voq_word_t             head;
    } rd_rsp_t;

    //////////////////////////////////////////////////
    // FSM states
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        idle,
        in_pkt,
        discard
    } framer_state_t;

    typedef enum logic {
        arbitrate,
        stream
    } sched_state_t;

endpackage

`default_nettype wire
